//--- src.f
+incdir+common
common/rv_pkg.sv
logic/fetch_stage.sv
decode/reg_file.sv
decode/decode_stage.sv
execute/execute_stage.sv
logic/result_stage.sv
logic/rv_core_top.sv
testbench/tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - common
    files:
      - common/rv_pkg.sv
      - logic/fetch_stage.sv
      - decode/reg_file.sv
      - decode/decode_stage.sv
      - execute/execute_stage.sv
      - logic/result_stage.sv
      - logic/rv_core_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/tb_rv_core.sv

//--- testbench/tb_rv_core.sv
////////////////////////////////////////////////////////////
// Runs a seeded random program of ADDI, ADD, SUB, LUI and
// forward JAL through the core and checks every retire in
// order against an ISA-level model. The program sits at the
// reset vector and ends with EBREAK.
////////////////////////////////////////////////////////////
`include "rv_macros.svh"

module tb_rv_core;
    import rv_pkg::*;

    localparam int PROG_N   = 41;
    localparam int TIMEOUT  = 500;
    localparam int K_ADDI   = 0;
    localparam int K_ADD    = 1;
    localparam int K_SUB    = 2;
    localparam int K_LUI    = 3;
    localparam int K_JAL    = 4;
    localparam int K_EBREAK = 5;

    logic                  clk = 1'b0;
    logic                  reset_i;
    logic [`RV_INST_W-1:0] inst_i;
    logic [`RV_XLEN-1:0]   thispc_i;
    logic [`RV_XLEN-1:0]   pc_o;
    logic                  ce_o;
    result_pkt_t           retire_o;
    logic                  halt_o;

    // Program slots and their fields
    logic [31:0]         prog [PROG_N];
    int                  kind [PROG_N];
    int                  rd_f [PROG_N];
    int                  rs1_f [PROG_N];
    int                  rs2_f [PROG_N];
    logic [19:0]         imm_f [PROG_N];

    // Expected retire sequence
    logic [`RV_XLEN-1:0] exp_pc [PROG_N];
    logic [4:0]          exp_rd [PROG_N];
    logic                exp_we [PROG_N];
    logic [`RV_XLEN-1:0] exp_wdata [PROG_N];
    logic                exp_halt [PROG_N];
    int                  model_n;
    int                  ret_idx;
    int                  seed;
    logic                reset_q = 1'b0;
    logic                req_seen;
    logic [`RV_XLEN-1:0] cur_pc;
    logic [4:0]          cur_rd;
    logic                cur_we;
    logic [`RV_XLEN-1:0] cur_wdata;
    logic                cur_halt;

    always #5 clk = ~clk;

    rv_core_top u_rv_core_top (
        .clk      (clk),
        .reset_i  (reset_i),
        .inst_i   (inst_i),
        .thispc_i (thispc_i),
        .pc_o     (pc_o),
        .ce_o     (ce_o),
        .retire_o (retire_o),
        .halt_o   (halt_o)
    );

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic report_value(input string name, input logic [63:0] exp_v,
                                input logic [63:0] act_v);
        $display("CHECK FAILED %s expected=%h actual=%h", name, exp_v, act_v);
        abort_run();
    endtask

    task automatic report_plain(input string msg);
        $display("%s", msg);
        abort_run();
    endtask

    function automatic logic [31:0] encode(input int kd, input int rd, input int rs1,
                                           input int rs2, input logic [19:0] imm);
        logic [20:0] off;
        // Word count to byte offset
        off = {imm[18:0], 2'b00};
        case (kd)
            K_ADDI:  return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], `RV_OP_IMM};
            K_ADD:   return {7'b0000000, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], `RV_OP_REG};
            K_SUB:   return {7'b0100000, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], `RV_OP_REG};
            K_LUI:   return {imm, rd[4:0], `RV_OP_LUI};
            K_JAL:   return {off[20], off[10:1], off[11], off[19:12], rd[4:0], `RV_OP_JAL};
            default: return 32'h0010_0073;
        endcase
    endfunction

    // Instruction memory, registered read
    function automatic logic [31:0] fetch_word(input logic [63:0] addr);
        logic [63:0] offs;
        logic [31:0] mix;
        offs = addr - `RV_RESET_VECTOR;
        mix  = addr[31:0] ^ addr[63:32];
        if (addr >= `RV_RESET_VECTOR && offs < 4 * PROG_N) begin
            return prog[offs[31:2]];
        end
        // Opcode 0 retires without a write
        return {mix[31:7] ^ mix[24:0], 7'b0};
    endfunction

    always @(posedge clk) begin
        if (ce_o === 1'b1) begin
            inst_i   <= fetch_word(pc_o);
            thispc_i <= pc_o;
        end
    end

    task automatic set_slot(input int i, input int kd, input int rd, input int rs1,
                            input int rs2, input logic [19:0] imm);
        kind[i]  = kd;
        rd_f[i]  = rd;
        rs1_f[i] = rs1;
        rs2_f[i] = rs2;
        imm_f[i] = imm;
    endtask

    task automatic build_program();
        int r;
        int k;
        for (int i = 0; i < PROG_N - 1; i++) begin
            r        = {$random(seed)} % 7;
            kind[i]  = (r < 3) ? K_ADDI : r - 2;
            rd_f[i]  = {$random(seed)} % 8;
            rs1_f[i] = {$random(seed)} % 8;
            rs2_f[i] = {$random(seed)} % 8;
            imm_f[i] = $random(seed);
            if (kind[i] == K_JAL) begin
                // Forward only, never past the EBREAK
                k        = 2 + {$random(seed)} % 3;
                imm_f[i] = (i + k > PROG_N - 1) ? PROG_N - 1 - i : k;
            end
        end
        // Dependency chain at distances 1, 2 and 3
        set_slot(0, K_ADDI, 1, 0, 0, 20'h00123);
        set_slot(1, K_ADDI, 2, 1, 0, 20'h00ffe);
        set_slot(2, K_ADD, 3, 1, 2, 20'h0);
        set_slot(3, K_SUB, 4, 1, 3, 20'h0);
        // Dropped write to x0, then a read of it
        set_slot(4, K_ADDI, 0, 1, 0, 20'h00055);
        set_slot(5, K_ADD, 5, 0, 0, 20'h0);
        // Skips slots 7 and 8, slot 9 reads the link value
        set_slot(6, K_JAL, 6, 0, 0, 20'h3);
        set_slot(9, K_ADD, 7, 6, 1, 20'h0);
        set_slot(PROG_N - 1, K_EBREAK, 0, 0, 0, 20'h0);
        for (int i = 0; i < PROG_N; i++) begin
            prog[i] = encode(kind[i], rd_f[i], rs1_f[i], rs2_f[i], imm_f[i]);
        end
    endtask

    task automatic run_model();
        logic [63:0] regs [32];
        logic [63:0] pc;
        logic [63:0] val;
        int          i;
        int          n;
        int          step;
        logic        done;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        pc   = `RV_RESET_VECTOR;
        i    = 0;
        n    = 0;
        done = 1'b0;
        while (!done) begin
            case (kind[i])
                K_ADDI:  val = regs[rs1_f[i]] + {{52{imm_f[i][11]}}, imm_f[i][11:0]};
                K_ADD:   val = regs[rs1_f[i]] + regs[rs2_f[i]];
                K_SUB:   val = regs[rs1_f[i]] - regs[rs2_f[i]];
                K_LUI:   val = {{32{imm_f[i][19]}}, imm_f[i], 12'b0};
                default: val = pc + 4;
            endcase
            exp_pc[n]    = pc;
            exp_rd[n]    = rd_f[i];
            exp_we[n]    = (kind[i] != K_EBREAK) && (rd_f[i] != 0);
            exp_wdata[n] = val;
            exp_halt[n]  = (kind[i] == K_EBREAK);
            if (exp_we[n]) begin
                regs[rd_f[i]] = val;
            end
            n++;
            done = (kind[i] == K_EBREAK);
            step = (kind[i] == K_JAL) ? imm_f[i] : 1;
            i    = i + step;
            pc   = pc + 4 * step;
        end
        model_n = n;
    endtask

    assign cur_pc    = exp_pc[ret_idx];
    assign cur_rd    = exp_rd[ret_idx];
    assign cur_we    = exp_we[ret_idx];
    assign cur_wdata = exp_wdata[ret_idx];
    assign cur_halt  = exp_halt[ret_idx];

    always @(posedge clk) begin
        reset_q <= reset_i;
        if (reset_i) begin
            ret_idx  <= 0;
            req_seen <= 1'b0;
        end else begin
            if (retire_o.valid) begin
                ret_idx <= ret_idx + 1;
            end
            if (ce_o) begin
                req_seen <= 1'b1;
            end
        end
    end

    // Reset state, first cycle skipped while DUT registers are unknown
    a_reset: assert property (@(posedge clk)
        reset_i && reset_q |-> !ce_o && !retire_o.valid && !halt_o)
        else report_plain("fetch, retire or halt active during reset");

    a_first_pc: assert property (@(posedge clk) disable iff (reset_i)
        ce_o && !req_seen |-> pc_o == `RV_RESET_VECTOR)
        else report_value("reset_first_pc", `RV_RESET_VECTOR, $sampled(pc_o));

    a_pc: assert property (@(posedge clk) disable iff (reset_i)
        retire_o.valid |-> retire_o.pc == cur_pc)
        else report_value("retire_pc", $sampled(cur_pc), $sampled(retire_o.pc));

    a_rd: assert property (@(posedge clk) disable iff (reset_i)
        retire_o.valid |-> retire_o.rd == cur_rd)
        else report_value("retire_rd", $sampled(cur_rd), $sampled(retire_o.rd));

    a_we: assert property (@(posedge clk) disable iff (reset_i)
        retire_o.valid |-> retire_o.we == cur_we)
        else report_value("retire_we", $sampled(cur_we), $sampled(retire_o.we));

    a_wdata: assert property (@(posedge clk) disable iff (reset_i)
        retire_o.valid && cur_we |-> retire_o.wdata == cur_wdata)
        else report_value("retire_wdata", $sampled(cur_wdata), $sampled(retire_o.wdata));

    a_halt: assert property (@(posedge clk) disable iff (reset_i)
        retire_o.valid |-> halt_o == cur_halt)
        else report_value("retire_halt", $sampled(cur_halt), $sampled(halt_o));

    a_halt_last: assert property (@(posedge clk) disable iff (reset_i)
        halt_o |-> ret_idx == model_n - 1)
        else report_value("halt_index", model_n - 1, $sampled(ret_idx));

    task automatic wait_for_fetch();
        int cycles;
        cycles = 0;
        while (ce_o !== 1'b1) begin
            @(posedge clk);
            cycles++;
            if (cycles >= TIMEOUT) begin
                report_plain("timeout: the core never raised its fetch request");
            end
        end
    endtask

    task automatic wait_for_halt();
        int cycles;
        cycles = 0;
        while (halt_o !== 1'b1) begin
            @(posedge clk);
            cycles++;
            if (cycles >= TIMEOUT) begin
                report_plain("timeout: the core never raised halt");
            end
        end
    endtask

    initial begin
        seed     = 32'hec35;
        reset_i  = 1'b1;
        inst_i   = '0;
        thispc_i = '0;
        build_program();
        run_model();
        repeat (2) @(posedge clk);
        reset_i <= 1'b0;
        wait_for_fetch();
        wait_for_halt();
        // Let the assertions of the halt edge finish
        #1;
        if (ret_idx == model_n) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            report_value("retire_count", model_n, ret_idx);
        end
    end

endmodule

//--- logic/rv_core_top.sv
////////////////////////////////////////////////////////////
// Four-stage RV64 core, no data memory and no stalls.
// retire_o reports every retired instruction including
// bubbles' absence. halt_o marks EBREAK retire.
////////////////////////////////////////////////////////////
`include "rv_macros.svh"

module rv_core_top (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic [`RV_INST_W-1:0] inst_i,
    input  logic [`RV_XLEN-1:0]   thispc_i,
    output logic [`RV_XLEN-1:0]   pc_o,
    output logic                  ce_o,
    output rv_pkg::result_pkt_t   retire_o,
    output logic                  halt_o
);
    import rv_pkg::*;

    fetch_pkt_t  fetch_pkt;
    decode_pkt_t decode_pkt;
    result_pkt_t ex_result;
    result_pkt_t res_fwd;
    redirect_t   redirect;

    fetch_stage u_fetch_stage (
        .clk        (clk),
        .reset_i    (reset_i),
        .inst_i     (inst_i),
        .thispc_i   (thispc_i),
        .redirect_i (redirect),
        .pc_o       (pc_o),
        .ce_o       (ce_o),
        .fetch_o    (fetch_pkt)
    );

    decode_stage u_decode_stage (
        .clk       (clk),
        .reset_i   (reset_i),
        .fetch_i   (fetch_pkt),
        .ex_fwd_i  (ex_result),
        .res_fwd_i (res_fwd),
        .wb_i      (retire_o),
        .decode_o  (decode_pkt)
    );

    execute_stage u_execute_stage (
        .clk        (clk),
        .reset_i    (reset_i),
        .decode_i   (decode_pkt),
        .result_o   (ex_result),
        .redirect_o (redirect)
    );

    // Second result register doubles as the writeback port
    result_stage u_result_stage (
        .clk       (clk),
        .reset_i   (reset_i),
        .result_i  (ex_result),
        .res_fwd_o (res_fwd),
        .wb_o      (retire_o),
        .halt_o    (halt_o)
    );

endmodule

//--- logic/result_stage.sv
////////////////////////////////////////////////////////////
// Two result registers in place of memory and writeback.
// The second one is the register file write port and the
// retire report. halt_o follows a retiring EBREAK.
////////////////////////////////////////////////////////////

module result_stage (
    input  logic                clk,
    input  logic                reset_i,
    input  rv_pkg::result_pkt_t result_i,
    output rv_pkg::result_pkt_t res_fwd_o,
    output rv_pkg::result_pkt_t wb_o,
    output logic                halt_o
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            res_fwd_o <= '0;
            wb_o      <= '0;
        end else begin
            res_fwd_o <= result_i;
            wb_o      <= res_fwd_o;
        end
    end

    // Raised in the retire cycle of EBREAK
    assign halt_o = wb_o.valid && wb_o.halt;

endmodule

//--- execute/execute_stage.sv
////////////////////////////////////////////////////////////
// Decode/execute register and ALU. A valid JAL here raises
// the redirect for one cycle and the next decode output is
// replaced by a bubble.
////////////////////////////////////////////////////////////
`include "rv_macros.svh"

module execute_stage (
    input  logic                clk,
    input  logic                reset_i,
    input  rv_pkg::decode_pkt_t decode_i,
    output rv_pkg::result_pkt_t result_o,
    output rv_pkg::redirect_t   redirect_o
);
    import rv_pkg::*;

    decode_pkt_t         ex_q;
    logic [`RV_XLEN-1:0] alu_res;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ex_q.valid <= 1'b0;
        end else if (redirect_o.valid) begin
            // Instruction behind the jump is on the wrong path
            ex_q.valid <= 1'b0;
        end else begin
            ex_q <= decode_i;
        end
    end

    always_comb begin
        case (ex_q.alu_op)
            ALU_ADD:    alu_res = ex_q.op_a + ex_q.op_b;
            ALU_SUB:    alu_res = ex_q.op_a - ex_q.op_b;
            ALU_PASS_B: alu_res = ex_q.op_b;
            // ALU_LINK, return address for JAL
            default:    alu_res = ex_q.pc + 'd4;
        endcase
    end

    always_comb begin
        result_o.valid = ex_q.valid;
        result_o.pc    = ex_q.pc;
        result_o.rd    = ex_q.rd;
        result_o.we    = ex_q.we;
        result_o.wdata = alu_res;
        result_o.halt  = ex_q.halt;
    end

    assign redirect_o.valid  = ex_q.valid && ex_q.is_jump;
    assign redirect_o.target = ex_q.jump_target;

endmodule

//--- decode/decode_stage.sv
////////////////////////////////////////////////////////////
// Decodes OP-IMM (as ADDI), ADD/SUB, LUI, JAL and EBREAK.
// funct3 is not checked. Operands are forwarded from
// execute, then the first result register, then the file.
////////////////////////////////////////////////////////////
`include "rv_macros.svh"

module decode_stage (
    input  logic                clk,
    input  logic                reset_i,
    input  rv_pkg::fetch_pkt_t  fetch_i,
    input  rv_pkg::result_pkt_t ex_fwd_i,
    input  rv_pkg::result_pkt_t res_fwd_i,
    input  rv_pkg::result_pkt_t wb_i,
    output rv_pkg::decode_pkt_t decode_o
);
    import rv_pkg::*;

    logic [6:0]                opcode;
    logic [`RV_REG_ADDR_W-1:0] rs1;
    logic [`RV_REG_ADDR_W-1:0] rs2;
    logic [`RV_REG_ADDR_W-1:0] rd;
    logic [`RV_XLEN-1:0]       rf_a;
    logic [`RV_XLEN-1:0]       rf_b;
    logic [`RV_XLEN-1:0]       src_a;
    logic [`RV_XLEN-1:0]       src_b;
    logic [`RV_XLEN-1:0]       imm_i;
    logic [`RV_XLEN-1:0]       imm_u;
    logic [`RV_XLEN-1:0]       imm_j;

    assign opcode = fetch_i.inst[6:0];
    assign rd     = fetch_i.inst[11:7];
    assign rs1    = fetch_i.inst[19:15];
    assign rs2    = fetch_i.inst[24:20];

    assign imm_i = {{(`RV_XLEN-12){fetch_i.inst[31]}}, fetch_i.inst[31:20]};
    assign imm_u = {{(`RV_XLEN-32){fetch_i.inst[31]}}, fetch_i.inst[31:12], 12'b0};
    assign imm_j = {{(`RV_XLEN-21){fetch_i.inst[31]}}, fetch_i.inst[31],
                    fetch_i.inst[19:12], fetch_i.inst[20], fetch_i.inst[30:21], 1'b0};

    reg_file u_reg_file (
        .clk       (clk),
        .reset_i   (reset_i),
        .we_i      (wb_i.valid && wb_i.we),
        .waddr_i   (wb_i.rd),
        .wdata_i   (wb_i.wdata),
        .raddr_a_i (rs1),
        .raddr_b_i (rs2),
        .rdata_a_o (rf_a),
        .rdata_b_o (rf_b)
    );

    // Youngest producer wins. we is never set for rd 0, so x0 never matches
    function automatic logic [`RV_XLEN-1:0] fwd_sel(
        input logic [`RV_REG_ADDR_W-1:0] rs,
        input logic [`RV_XLEN-1:0]       rf_data,
        input result_pkt_t               ex,
        input result_pkt_t               res
    );
        if (ex.valid && ex.we && ex.rd == rs) begin
            return ex.wdata;
        end
        if (res.valid && res.we && res.rd == rs) begin
            return res.wdata;
        end
        return rf_data;
    endfunction

    assign src_a = fwd_sel(rs1, rf_a, ex_fwd_i, res_fwd_i);
    assign src_b = fwd_sel(rs2, rf_b, ex_fwd_i, res_fwd_i);

    always_comb begin
        decode_o             = '0;
        decode_o.valid       = fetch_i.valid;
        decode_o.pc          = fetch_i.pc;
        decode_o.rd          = rd;
        decode_o.op_a        = src_a;
        decode_o.alu_op      = ALU_ADD;
        decode_o.jump_target = fetch_i.pc + imm_j;
        case (opcode)
            `RV_OP_IMM: begin
                decode_o.op_b = imm_i;
                decode_o.we   = 1'b1;
            end
            `RV_OP_REG: begin
                // funct7 bit 5 selects SUB
                decode_o.op_b   = src_b;
                decode_o.alu_op = fetch_i.inst[30] ? ALU_SUB : ALU_ADD;
                decode_o.we     = 1'b1;
            end
            `RV_OP_LUI: begin
                decode_o.op_b   = imm_u;
                decode_o.alu_op = ALU_PASS_B;
                decode_o.we     = 1'b1;
            end
            `RV_OP_JAL: begin
                decode_o.alu_op  = ALU_LINK;
                decode_o.is_jump = 1'b1;
                decode_o.we      = 1'b1;
            end
            `RV_OP_SYSTEM: begin
                // EBREAK only, other SYSTEM forms pass as no-ops
                decode_o.halt = (fetch_i.inst[31:7] == 25'h0002000);
            end
            default: begin
                decode_o.we = 1'b0;
            end
        endcase
        if (rd == '0) begin
            decode_o.we = 1'b0;
        end
    end

endmodule

//--- decode/reg_file.sv
////////////////////////////////////////////////////////////
// 31 x 64-bit integer registers, x0 reads as zero.
// Reads are combinational and see a write in the same cycle.
////////////////////////////////////////////////////////////
`include "rv_macros.svh"

module reg_file (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      we_i,
    input  logic [`RV_REG_ADDR_W-1:0] waddr_i,
    input  logic [`RV_XLEN-1:0]       wdata_i,
    input  logic [`RV_REG_ADDR_W-1:0] raddr_a_i,
    input  logic [`RV_REG_ADDR_W-1:0] raddr_b_i,
    output logic [`RV_XLEN-1:0]       rdata_a_o,
    output logic [`RV_XLEN-1:0]       rdata_b_o
);

    logic [`RV_XLEN-1:0]       regs_q [1:31];
    logic [`RV_REG_ADDR_W-1:0] raddr [2];
    logic [`RV_XLEN-1:0]       rdata [2];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    assign raddr[0] = raddr_a_i;
    assign raddr[1] = raddr_b_i;

    // Write-through covers the writeback cycle itself
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            if (raddr[p] == '0) begin
                rdata[p] = '0;
            end else if (we_i && waddr_i == raddr[p]) begin
                rdata[p] = wdata_i;
            end else begin
                rdata[p] = regs_q[raddr[p]];
            end
        end
    end

    assign rdata_a_o = rdata[0];
    assign rdata_b_o = rdata[1];

endmodule

//--- logic/fetch_stage.sv
////////////////////////////////////////////////////////////
// PC and fetch request. The instruction memory must return
// the word one cycle after each ce_o edge and never stall.
// ce_o stays high from the first cycle after reset.
////////////////////////////////////////////////////////////
`include "rv_macros.svh"

module fetch_stage (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic [`RV_INST_W-1:0] inst_i,
    input  logic [`RV_XLEN-1:0]   thispc_i,
    input  rv_pkg::redirect_t     redirect_i,
    output logic [`RV_XLEN-1:0]   pc_o,
    output logic                  ce_o,
    output rv_pkg::fetch_pkt_t    fetch_o
);

    // Memory accepted a request at the previous edge
    logic inflight_q;
    // Word now on inst_i was requested on the old path
    logic drop_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ce_o       <= 1'b0;
            pc_o       <= `RV_RESET_VECTOR;
            inflight_q <= 1'b0;
            drop_q     <= 1'b0;
        end else begin
            ce_o       <= 1'b1;
            inflight_q <= ce_o;
            drop_q     <= redirect_i.valid;
            if (redirect_i.valid) begin
                pc_o <= redirect_i.target;
            end else if (ce_o) begin
                pc_o <= pc_o + 'd4;
            end
        end
    end

    // Fetch/decode register
    always_ff @(posedge clk) begin
        if (reset_i) begin
            fetch_o.valid <= 1'b0;
        end else begin
            fetch_o.valid <= inflight_q && !drop_q && !redirect_i.valid;
            fetch_o.pc    <= thispc_i;
            fetch_o.inst  <= inst_i;
        end
    end

endmodule

//--- common/rv_pkg.sv
////////////////////////////////////////////////////////////
// Stage-to-stage packets and the ALU operation encoding.
// A packet with valid low is a bubble. Its other fields
// carry no meaning.
////////////////////////////////////////////////////////////
`include "rv_macros.svh"

package rv_pkg;

    typedef enum logic [1:0] {
        ALU_ADD    = 2'd0,
        ALU_SUB    = 2'd1,
        ALU_PASS_B = 2'd2,
        ALU_LINK   = 2'd3
    } alu_op_e;

    // Fetch/decode register contents
    typedef struct packed {
        logic                      valid;
        logic [`RV_XLEN-1:0]       pc;
        logic [`RV_INST_W-1:0]     inst;
    } fetch_pkt_t;

    // Decode/execute register contents, operands already forwarded
    typedef struct packed {
        logic                      valid;
        logic [`RV_XLEN-1:0]       pc;
        alu_op_e                   alu_op;
        logic [`RV_XLEN-1:0]       op_a;
        logic [`RV_XLEN-1:0]       op_b;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic                      we;
        logic                      is_jump;
        logic [`RV_XLEN-1:0]       jump_target;
        logic                      halt;
    } decode_pkt_t;

    // Completed result, also used for forwarding and retire
    typedef struct packed {
        logic                      valid;
        logic [`RV_XLEN-1:0]       pc;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic                      we;
        logic [`RV_XLEN-1:0]       wdata;
        logic                      halt;
    } result_pkt_t;

    typedef struct packed {
        logic                      valid;
        logic [`RV_XLEN-1:0]       target;
    } redirect_t;

endpackage

//--- common/rv_macros.svh
////////////////////////////////////////////////////////////
// Widths, reset vector and major opcodes for the RV64 core.
// Only the five opcodes below are decoded. Anything else
// retires without a register write.
////////////////////////////////////////////////////////////
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// Data path and program counter width
`define RV_XLEN         64
`define RV_REG_ADDR_W   5
`define RV_INST_W       32

// First fetch address after reset
`define RV_RESET_VECTOR 64'h8000_0000

// Major opcodes, inst[6:0]
`define RV_OP_IMM       7'b0010011
`define RV_OP_REG       7'b0110011
`define RV_OP_LUI       7'b0110111
`define RV_OP_JAL       7'b1101111
`define RV_OP_SYSTEM    7'b1110011

`endif
